// ==== apu_dispatcher.sv ====
`timescale 1ns/1ps

module apu_dispatcher (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Request from the core
  input  logic                             enable_i,
  input  apu_pkg::apu_lat_e                lat_i,
  input  logic [apu_pkg::RegAddrWidth-1:0] waddr_i,
  // Hazard queries from decode
  input  logic                             is_decoding_i,
  input  apu_pkg::dep_query_t              dep_i,
  // Execution unit handshake and response
  input  logic                             apu_gnt_i,
  input  logic                             apu_valid_i,
  output logic                             apu_req_o,
  output logic [apu_pkg::RegAddrWidth-1:0] wb_addr_o,
  // Status towards the core
  output logic                             active_o,
  output logic                             stall_o,
  output logic                             read_dep_o,
  output logic                             write_dep_o,
  output apu_pkg::apu_perf_t               perf_o
);

  import apu_pkg::*;

  logic [RegAddrWidth-1:0] addr_inflight_q, addr_inflight_d;
  logic [RegAddrWidth-1:0] addr_waiting_q, addr_waiting_d;
  logic                    valid_inflight_q, valid_inflight_d;
  logic                    valid_waiting_q, valid_waiting_d;
  apu_lat_e                lat_q;

  logic valid_req, req_accepted, multi_issue, active;
  logic returned_req, returned_inflight, returned_waiting;
  logic stall_full, stall_type, stall_nack;

  logic [NumReadPorts-1:0]  rd_hit_req, rd_hit_inflight, rd_hit_waiting;
  logic [NumWritePorts-1:0] wr_hit_req, wr_hit_inflight, wr_hit_waiting;
  logic                     req_pending;

  //////////////////////////////////////////////////
  // Issue and return
  //////////////////////////////////////////////////

  // Nack stalls still present the request so the grant can arrive
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign req_accepted = valid_req & apu_gnt_i;
  // Anything not combinational must be tracked
  assign multi_issue  = req_accepted & (lat_i != LatComb);

  // Combinational op answers in its own issue cycle
  // The unit never grants it while an older result is due
  assign returned_req      = req_accepted & (lat_i == LatComb) & apu_valid_i;
  // Oldest entry retires first
  assign returned_waiting  = apu_valid_i & ~returned_req & valid_waiting_q;
  assign returned_inflight = apu_valid_i & ~returned_req & valid_inflight_q & ~valid_waiting_q;

  //////////////////////////////////////////////////
  // Outstanding operation tracker
  //////////////////////////////////////////////////

  always_comb begin
    valid_inflight_d = valid_inflight_q;
    valid_waiting_d  = valid_waiting_q;
    addr_inflight_d  = addr_inflight_q;
    addr_waiting_d   = addr_waiting_q;

    // Retire first, a new issue may refill the slot
    if (returned_waiting) begin
      valid_waiting_d = 1'b0;
    end
    if (returned_inflight) begin
      valid_inflight_d = 1'b0;
    end

    if (multi_issue) begin
      valid_inflight_d = 1'b1;
      addr_inflight_d  = waddr_i;
      // Older op still outstanding, push it down to waiting
      if (valid_inflight_q & ~returned_inflight) begin
        valid_waiting_d = 1'b1;
        addr_waiting_d  = addr_inflight_q;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight_q <= 1'b0;
      valid_waiting_q  <= 1'b0;
    end else begin
      valid_inflight_q <= valid_inflight_d;
      valid_waiting_q  <= valid_waiting_d;
    end
  end

  // Addresses only matter while their valid bit is set
  always_ff @(posedge clk_i) begin
    addr_inflight_q <= addr_inflight_d;
    addr_waiting_q  <= addr_waiting_d;
  end

  // Latency class of the most recent issue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_q <= LatComb;
    end else if (req_accepted) begin
      lat_q <= lat_i;
    end
  end

  assign active = valid_inflight_q | valid_waiting_q;

  //////////////////////////////////////////////////
  // Dependency checks
  //////////////////////////////////////////////////

  // Presented request counts unless it completes right now
  assign req_pending = valid_req & ~returned_req;

  for (genvar i = 0; i < NumReadPorts; i++) begin : g_rd_dep
    assign rd_hit_req[i]      = dep_i.read_valid[i] & (dep_i.read_regs[i] == waddr_i);
    assign rd_hit_inflight[i] = dep_i.read_valid[i] & (dep_i.read_regs[i] == addr_inflight_q);
    assign rd_hit_waiting[i]  = dep_i.read_valid[i] & (dep_i.read_regs[i] == addr_waiting_q);
  end

  for (genvar i = 0; i < NumWritePorts; i++) begin : g_wr_dep
    assign wr_hit_req[i]      = dep_i.write_valid[i] & (dep_i.write_regs[i] == waddr_i);
    assign wr_hit_inflight[i] = dep_i.write_valid[i] & (dep_i.write_regs[i] == addr_inflight_q);
    assign wr_hit_waiting[i]  = dep_i.write_valid[i] & (dep_i.write_regs[i] == addr_waiting_q);
  end

  // A slot returning this cycle no longer blocks decode
  assign read_dep_o = is_decoding_i & (
      (|rd_hit_req      & req_pending) |
      (|rd_hit_inflight & valid_inflight_q & ~returned_inflight) |
      (|rd_hit_waiting  & valid_waiting_q  & ~returned_waiting));

  assign write_dep_o = is_decoding_i & (
      (|wr_hit_req      & req_pending) |
      (|wr_hit_inflight & valid_inflight_q & ~returned_inflight) |
      (|wr_hit_waiting  & valid_waiting_q  & ~returned_waiting));

  //////////////////////////////////////////////////
  // Stalls
  //////////////////////////////////////////////////

  // Both slots taken
  assign stall_full = valid_inflight_q & valid_waiting_q;
  // Shorter latency behind a longer one would overtake it
  assign stall_type = enable_i & active &
                      ((lat_i == LatOne) | (lat_i == LatMulti) |
                       ((lat_i == LatTwo) & (lat_q == LatMulti)));
  // Unit busy or result slot taken
  assign stall_nack = valid_req & ~apu_gnt_i;

  assign stall_o = stall_full | stall_type | stall_nack;

  // Write-back address follows the returning slot
  always_comb begin
    wb_addr_o = '0;
    if (returned_req) begin
      wb_addr_o = waddr_i;
    end else if (returned_waiting) begin
      wb_addr_o = addr_waiting_q;
    end else if (returned_inflight) begin
      wb_addr_o = addr_inflight_q;
    end
  end

  assign apu_req_o         = valid_req;
  assign active_o          = active;
  assign perf_o.stall_type = stall_type;
  assign perf_o.stall_nack = stall_nack;

endmodule

// ==== apu_exec_unit.sv ====
`timescale 1ns/1ps

module apu_exec_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          issue_i,
  input  apu_pkg::apu_req_t             req_i,
  output logic                          gnt_o,
  output logic                          valid_o,
  output logic [apu_pkg::DataWidth-1:0] result_o
);

  import apu_pkg::*;

  // Class 0 to 2 function
  function automatic logic [DataWidth-1:0] alu_fn(apu_op_e op, logic [DataWidth-1:0] a,
                                                 logic [DataWidth-1:0] b);
    logic [DataWidth-1:0] res;
    unique case (op)
      OpAdd:   res = a + b;
      OpSub:   res = a - b;
      OpAnd:   res = a & b;
      default: res = a ^ b;
    endcase
    return res;
  endfunction

  // Radix-4 partial product, low bits only
  function automatic logic [DataWidth-1:0] mul_pp(logic [DataWidth-1:0] mcand, logic [1:0] bits);
    logic [DataWidth-1:0] pp;
    unique case (bits)
      2'd0:    pp = '0;
      2'd1:    pp = mcand;
      2'd2:    pp = mcand << 1;
      default: pp = mcand + (mcand << 1);
    endcase
    return pp;
  endfunction

  logic                   fire, fire_comb, fire_pipe, fire_mul;
  logic [DataWidth-1:0]   alu_res;

  // Two-stage pipeline for classes 1 and 2
  logic                   sta_valid_q, sta_two_q, stb_valid_q;
  logic [DataWidth-1:0]   sta_data_q, stb_data_q;
  logic                   sta_out, due_now;

  // Iterative multiplier
  logic                   mul_busy_q;
  logic [MulCntWidth-1:0] mul_cnt_q;
  logic [DataWidth-1:0]   mcand_q, mplier_q, acc_q;
  logic                   mul_done;

  assign alu_res   = alu_fn(req_i.op, req_i.operand_a, req_i.operand_b);
  assign fire      = issue_i & gnt_o;
  assign fire_comb = fire & (req_i.lat == LatComb);
  assign fire_pipe = fire & ((req_i.lat == LatOne) | (req_i.lat == LatTwo));
  assign fire_mul  = fire & (req_i.lat == LatMulti);

  //////////////////////////////////////////////////
  // Classes 1 and 2
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sta_valid_q <= 1'b0;
      sta_two_q   <= 1'b0;
      stb_valid_q <= 1'b0;
    end else begin
      sta_valid_q <= fire_pipe;
      sta_two_q   <= fire_pipe & (req_i.lat == LatTwo);
      // Only class 2 moves on to the second stage
      stb_valid_q <= sta_valid_q & sta_two_q;
    end
  end

  always_ff @(posedge clk_i) begin
    sta_data_q <= alu_res;
    stb_data_q <= sta_data_q;
  end

  // Class 1 leaves from the first stage
  assign sta_out = sta_valid_q & ~sta_two_q;

  //////////////////////////////////////////////////
  // Class 3 multiplier
  //////////////////////////////////////////////////

  // First partial product is taken in the issue cycle,
  // so the counter starts one short
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mul_busy_q <= 1'b0;
      mul_cnt_q  <= '0;
    end else if (fire_mul) begin
      mul_busy_q <= 1'b1;
      mul_cnt_q  <= MulCntWidth'(MulCycles - 1);
    end else if (mul_done) begin
      mul_busy_q <= 1'b0;
    end else if (mul_busy_q) begin
      mul_cnt_q <= mul_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire_mul) begin
      acc_q    <= mul_pp(req_i.operand_a, req_i.operand_b[1:0]);
      mcand_q  <= req_i.operand_a << 2;
      mplier_q <= req_i.operand_b >> 2;
    end else if (mul_busy_q && mul_cnt_q != '0) begin
      acc_q    <= acc_q + mul_pp(mcand_q, mplier_q[1:0]);
      mcand_q  <= mcand_q << 2;
      mplier_q <= mplier_q >> 2;
    end
  end

  assign mul_done = mul_busy_q & (mul_cnt_q == '0);

  //////////////////////////////////////////////////
  // Grant and result mux
  //////////////////////////////////////////////////

  // Result slot already claimed this cycle
  assign due_now = sta_out | stb_valid_q | mul_done;

  assign gnt_o = ~mul_busy_q & ~((req_i.lat == LatComb) & due_now);

  assign valid_o = fire_comb | due_now;

  always_comb begin
    result_o = '0;
    if (fire_comb) begin
      result_o = alu_res;
    end else if (sta_out) begin
      result_o = sta_data_q;
    end else if (stb_valid_q) begin
      result_o = stb_data_q;
    end else if (mul_done) begin
      result_o = acc_q;
    end
  end

endmodule

// ==== apu_issue_top.sv ====
`timescale 1ns/1ps

module apu_issue_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Core request
  input  logic                             enable_i,
  input  apu_pkg::apu_req_t                req_i,
  // Decode hazard query
  input  logic                             is_decoding_i,
  input  apu_pkg::dep_query_t              dep_i,
  // Register file read port
  input  logic [apu_pkg::RegAddrWidth-1:0] rd_addr_i,
  // Status
  output logic                             stall_o,
  output logic                             active_o,
  output logic                             read_dep_o,
  output logic                             write_dep_o,
  output apu_pkg::apu_perf_t               perf_o,
  output logic [apu_pkg::DataWidth-1:0]    rd_data_o
);

  import apu_pkg::*;

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  // Dispatcher to unit handshake
  logic                    apu_req, apu_gnt;
  // Result return path
  logic                    apu_valid;
  logic [RegAddrWidth-1:0] wb_addr;
  logic [DataWidth-1:0]    result;

  apu_dispatcher i_dispatcher (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable_i),
    .lat_i         (req_i.lat),
    .waddr_i       (req_i.waddr),
    .is_decoding_i (is_decoding_i),
    .dep_i         (dep_i),
    .apu_gnt_i     (apu_gnt),
    .apu_valid_i   (apu_valid),
    .apu_req_o     (apu_req),
    .wb_addr_o     (wb_addr),
    .active_o      (active_o),
    .stall_o       (stall_o),
    .read_dep_o    (read_dep_o),
    .write_dep_o   (write_dep_o),
    .perf_o        (perf_o)
  );

  // Unit sees the full request, issue is qualified by the strobe
  apu_exec_unit i_exec_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .issue_i  (apu_req),
    .req_i    (req_i),
    .gnt_o    (apu_gnt),
    .valid_o  (apu_valid),
    .result_o (result)
  );

  apu_wb_regfile i_wb_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (apu_valid),
    .waddr_i (wb_addr),
    .wdata_i (result),
    .raddr_i (rd_addr_i),
    .rdata_o (rd_data_o)
  );

endmodule

// ==== apu_pkg.sv ====
package apu_pkg;

  // Register file geometry
  localparam int unsigned RegAddrWidth = 6;
  localparam int unsigned NumRegs      = 64;
  localparam int unsigned DataWidth    = 32;

  // Iterative multiplier retires 2 multiplier bits per cycle
  localparam int unsigned MulCycles   = 16;
  localparam int unsigned MulCntWidth = $clog2(MulCycles);

  // Dependency query ports from decode
  localparam int unsigned NumReadPorts  = 3;
  localparam int unsigned NumWritePorts = 2;

  // Latency class of an operation
  typedef enum logic [1:0] {
    LatComb  = 2'd0,
    LatOne   = 2'd1,
    LatTwo   = 2'd2,
    LatMulti = 2'd3
  } apu_lat_e;

  // Function for classes 0 to 2, class 3 always multiplies
  typedef enum logic [1:0] {
    OpAdd = 2'd0,
    OpSub = 2'd1,
    OpAnd = 2'd2,
    OpXor = 2'd3
  } apu_op_e;

  // Operation as presented by the core
  typedef struct packed {
    apu_op_e                op;
    apu_lat_e               lat;
    logic [RegAddrWidth-1:0] waddr;
    logic [DataWidth-1:0]   operand_a;
    logic [DataWidth-1:0]   operand_b;
  } apu_req_t;

  // Decode-stage register usage for hazard detection
  typedef struct packed {
    logic [NumReadPorts-1:0][RegAddrWidth-1:0]  read_regs;
    logic [NumReadPorts-1:0]                    read_valid;
    logic [NumWritePorts-1:0][RegAddrWidth-1:0] write_regs;
    logic [NumWritePorts-1:0]                   write_valid;
  } dep_query_t;

  // Stall reasons for performance counters
  typedef struct packed {
    logic stall_type;
    logic stall_nack;
  } apu_perf_t;

endpackage

// ==== apu_wb_regfile.sv ====
`timescale 1ns/1ps

module apu_wb_regfile (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Write port from the returning result
  input  logic                             we_i,
  input  logic [apu_pkg::RegAddrWidth-1:0] waddr_i,
  input  logic [apu_pkg::DataWidth-1:0]    wdata_i,
  // Read port
  input  logic [apu_pkg::RegAddrWidth-1:0] raddr_i,
  output logic [apu_pkg::DataWidth-1:0]    rdata_o
);

  import apu_pkg::*;

  logic [DataWidth-1:0] regs_q [NumRegs];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // All entries start at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{default: '0};
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous read
  // a same-cycle write shows up on the next cycle
  assign rdata_o = regs_q[raddr_i];

endmodule

// ==== files.f ====
apu_pkg.sv
apu_dispatcher.sv
apu_exec_unit.sv
apu_wb_regfile.sv
apu_issue_top.sv
tb_apu_issue_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then judge the result from the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -Wno-fatal --top-module tb_apu_issue_top \
  -f files.f -o sim_apu &&
{ ./obj_dir/sim_apu > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx '>>> PASS' sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== tb_apu_issue_top.sv ====
`timescale 1ns/1ps

module tb_apu_issue_top;

  import apu_pkg::*;

  localparam int unsigned NumOps     = 300;
  // Worst case is every op a multiply plus a few cycles of stall
  localparam int unsigned CycleLimit = NumOps * (MulCycles + 4) + 200;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    enable_i;
  logic                    is_decoding_i;
  apu_req_t                req_i;
  dep_query_t              dep_i;
  logic [RegAddrWidth-1:0] rd_addr_i;
  logic                    stall_o;
  logic                    active_o;
  logic                    read_dep_o;
  logic                    write_dep_o;
  apu_perf_t               perf_o;
  logic [DataWidth-1:0]    rd_data_o;

  // Reference model state
  logic [DataWidth-1:0]    exp_regs [NumRegs] = '{default: '0};
  int unsigned             ent_rem [$];
  logic [RegAddrWidth-1:0] ent_dest [$];
  logic [DataWidth-1:0]    ent_val [$];
  apu_lat_e                ent_lat [$];
  apu_lat_e                last_lat    = LatComb;
  logic                    issue_seen  = 1'b0;
  int unsigned             num_issued  = 0;
  int unsigned             num_sent    = 0;
  int unsigned             cycle_cnt   = 0;
  logic [RegAddrWidth-1:0] recent_dest [4] = '{default: '0};

  apu_issue_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable_i),
    .req_i         (req_i),
    .is_decoding_i (is_decoding_i),
    .dep_i         (dep_i),
    .rd_addr_i     (rd_addr_i),
    .stall_o       (stall_o),
    .active_o      (active_o),
    .read_dep_o    (read_dep_o),
    .write_dep_o   (write_dep_o),
    .perf_o        (perf_o),
    .rd_data_o     (rd_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
      else report_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] exp);
    assert (got === exp)
      else report_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Result by the package rules, multiply keeps the low word
  function automatic logic [DataWidth-1:0] expected_result(apu_req_t r);
    logic [2*DataWidth-1:0] prod;
    prod = {{DataWidth{1'b0}}, r.operand_a} * {{DataWidth{1'b0}}, r.operand_b};
    if (r.lat == LatMulti) begin
      return prod[DataWidth-1:0];
    end
    case (r.op)
      OpAdd:   return r.operand_a + r.operand_b;
      OpSub:   return r.operand_a + ~r.operand_b + 1'b1;
      OpAnd:   return r.operand_a & r.operand_b;
      default: return r.operand_a ^ r.operand_b;
    endcase
  endfunction

  function automatic int unsigned return_delay(apu_lat_e lat);
    case (lat)
      LatOne:  return 1;
      LatTwo:  return 2;
      default: return MulCycles;
    endcase
  endfunction

  function automatic apu_req_t random_req();
    apu_req_t r;
    r.op        = apu_op_e'($urandom_range(3, 0));
    r.lat       = apu_lat_e'($urandom_range(3, 0));
    r.waddr     = RegAddrWidth'($urandom_range(NumRegs - 1, 0));
    r.operand_a = $urandom();
    r.operand_b = $urandom();
    return r;
  endfunction

  // Half the queries aim at recent destinations so hazards show up
  function automatic logic [RegAddrWidth-1:0] pick_query_addr();
    if ($urandom_range(1, 0) == 1) begin
      return recent_dest[$urandom_range(3, 0)];
    end
    return RegAddrWidth'($urandom_range(NumRegs - 1, 0));
  endfunction

  task automatic drive_dep_query();
    dep_query_t q;
    for (int p = 0; p < NumReadPorts; p++) begin
      q.read_regs[p]  = pick_query_addr();
      q.read_valid[p] = 1'($urandom_range(1, 0));
    end
    for (int p = 0; p < NumWritePorts; p++) begin
      q.write_regs[p]  = pick_query_addr();
      q.write_valid[p] = 1'($urandom_range(1, 0));
    end
    dep_i         <= q;
    is_decoding_i <= ($urandom_range(7, 0) != 0);
  endtask

  // Destination still owed by the unit, or by the request on the port
  function automatic logic dest_outstanding(logic [RegAddrWidth-1:0] addr, logic req_counts);
    logic hit;
    hit = req_counts && (addr == req_i.waddr);
    foreach (ent_dest[i]) begin
      // Returning this cycle means decode may go ahead
      if (ent_rem[i] > 1 && ent_dest[i] == addr) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  //////////////////////////////////////////////////
  // Reference model and cycle checks
  //////////////////////////////////////////////////

  // Sampled mid-cycle, all inputs settled since the rising edge
  always @(negedge clk_i) begin : model_check
    logic mul_busy, due_now, exp_full, exp_type, exp_nack, req_counts, exp_rd, exp_wr;
    if (rst_ni) begin
      mul_busy = 1'b0;
      due_now  = 1'b0;
      foreach (ent_rem[i]) begin
        mul_busy = mul_busy | (ent_lat[i] == LatMulti);
        due_now  = due_now | (ent_rem[i] == 1);
      end
      exp_full = (ent_rem.size() == 2);
      exp_type = enable_i && (ent_rem.size() != 0) &&
                 (req_i.lat == LatOne || req_i.lat == LatMulti ||
                  (req_i.lat == LatTwo && last_lat == LatMulti));
      // Busy multiplier, or a result already owns this cycle
      exp_nack = enable_i && !exp_full && !exp_type &&
                 (mul_busy || (req_i.lat == LatComb && due_now));
      check_bit("active_o", active_o, ent_rem.size() != 0);
      check_bit("stall_o", stall_o, exp_full | exp_type | exp_nack);
      check_bit("perf_o.stall_type", perf_o.stall_type, exp_type);
      check_bit("perf_o.stall_nack", perf_o.stall_nack, exp_nack);

      // Request on the port blocks unless it finishes right now
      req_counts = enable_i && !exp_full && !exp_type && (exp_nack || req_i.lat != LatComb);
      exp_rd = 1'b0;
      exp_wr = 1'b0;
      for (int p = 0; p < NumReadPorts; p++) begin
        exp_rd = exp_rd | (dep_i.read_valid[p] && dest_outstanding(dep_i.read_regs[p], req_counts));
      end
      for (int p = 0; p < NumWritePorts; p++) begin
        exp_wr = exp_wr |
                 (dep_i.write_valid[p] && dest_outstanding(dep_i.write_regs[p], req_counts));
      end
      check_bit("read_dep_o", read_dep_o, exp_rd && is_decoding_i);
      check_bit("write_dep_o", write_dep_o, exp_wr && is_decoding_i);

      // Commit in return order, not issue order
      for (int i = ent_rem.size() - 1; i >= 0; i--) begin
        ent_rem[i] = ent_rem[i] - 1;
        if (ent_rem[i] == 0) begin
          exp_regs[ent_dest[i]] = ent_val[i];
          ent_rem.delete(i);
          ent_dest.delete(i);
          ent_val.delete(i);
          ent_lat.delete(i);
        end
      end

      issue_seen = enable_i && !stall_o;
      if (issue_seen) begin
        num_issued++;
        last_lat = req_i.lat;
        if (req_i.lat == LatComb) begin
          exp_regs[req_i.waddr] = expected_result(req_i);
        end else begin
          ent_rem.push_back(return_delay(req_i.lat));
          ent_dest.push_back(req_i.waddr);
          ent_val.push_back(expected_result(req_i));
          ent_lat.push_back(req_i.lat);
        end
      end
    end
  end

  // Decode idle never reports a hazard
  no_dep_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !is_decoding_i |-> !(read_dep_o || write_dep_o))
    else report_failure($sformatf("CHECK FAILED read_dep_o/write_dep_o: got 0x%0h, expected 0x0",
                                  {$sampled(read_dep_o), $sampled(write_dep_o)}));

  // Any stall reason must show on stall_o
  reason_implies_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (perf_o.stall_type || perf_o.stall_nack) |-> stall_o)
    else report_failure($sformatf("CHECK FAILED stall_o: got 0x%0h, expected 0x1",
                                  $sampled(stall_o)));

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      report_failure($sformatf("Timeout: run did not finish within %0d cycles", CycleLimit));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    apu_req_t next_req;
    void'($urandom(32'h4623));
    rst_ni        = 1'b0;
    enable_i      = 1'b0;
    is_decoding_i = 1'b0;
    req_i         = '0;
    dep_i         = '0;
    rd_addr_i     = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Hold each request until the model saw it issue
    while (num_issued < NumOps) begin
      @(posedge clk_i);
      if (!enable_i || issue_seen) begin
        if (num_sent < NumOps && $urandom_range(3, 0) != 0) begin
          next_req = random_req();
          recent_dest[num_sent % 4] = next_req.waddr;
          enable_i <= 1'b1;
          req_i    <= next_req;
          num_sent++;
        end else begin
          enable_i <= 1'b0;
        end
      end
      drive_dep_query();
    end
    @(posedge clk_i);
    enable_i      <= 1'b0;
    is_decoding_i <= 1'b0;

    // Drain the unit
    do begin
      @(negedge clk_i);
    end while (active_o);

    for (int r = 0; r < NumRegs; r++) begin
      @(posedge clk_i);
      rd_addr_i <= RegAddrWidth'(r);
      @(negedge clk_i);
      check_word($sformatf("rd_data_o[%0d]", r), rd_data_o, exp_regs[r]);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule
